//--- hdl/rv_pkg.sv
`default_nettype none

package rv_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_idx_t;

    // RV32I major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B
    } alu_op_e;

    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t inst;
    } if_id_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        reg_idx_t rd;
        logic     rd_wen;
        word_t    rs1_value;   // Already forwarded
        word_t    rs2_value;
        word_t    imm;
        alu_op_e  alu_op;
        logic     use_imm;
        logic     is_load;
        logic     is_store;
        logic     is_branch;
        logic     branch_ne;
        logic     is_jump;
    } id_ex_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        reg_idx_t rd;
        logic     rd_wen;
        logic     is_load;
        logic     is_store;
        word_t    result;
        word_t    store_data;
    } ex_mem_t;

    // Also the register file write bus
    typedef struct packed {
        logic     valid;
        word_t    pc;
        reg_idx_t rd;
        logic     rd_wen;
        word_t    value;
    } retire_t;

    typedef struct packed {
        logic  ren;
        logic  wen;
        word_t addr;
        word_t wdata;
    } dmem_req_t;

    typedef struct packed {
        logic  valid;
        word_t target;
    } redirect_t;

endpackage

`default_nettype wire

//--- hdl/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_stage #(
    parameter rv_pkg::word_t RESET_PC = 32'h0000_0000
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              stall,
    input  rv_pkg::redirect_t redirect,
    input  rv_pkg::word_t     imem_data,
    output rv_pkg::word_t     imem_addr,
    output rv_pkg::if_id_t    if_id
);
    import rv_pkg::*;

    word_t pc;
    word_t pc_next;

    assign imem_addr = pc;

    always_comb begin
        if (redirect.valid)
            pc_next = redirect.target;   // Redirect beats stall
        else if (stall)
            pc_next = pc;
        else
            pc_next = pc + 32'd4;
    end

    always_ff @(posedge clk) begin
        if (!stall || redirect.valid) begin
            if_id.pc   <= pc;
            if_id.inst <= imem_data;
        end
        if (rst) begin
            pc          <= RESET_PC;
            if_id.valid <= 1'b0;
        end else begin
            pc <= pc_next;
            if (redirect.valid)
                if_id.valid <= 1'b0;
            else if (!stall)
                if_id.valid <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- hdl/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic             clk,
    input  rv_pkg::reg_idx_t rs1,
    input  rv_pkg::reg_idx_t rs2,
    input  rv_pkg::retire_t  wb,
    output rv_pkg::word_t    rs1_value,
    output rv_pkg::word_t    rs2_value
);
    import rv_pkg::*;

    word_t regs [1:31];   // x0 has no storage
    logic  wb_write;

    assign wb_write = wb.valid && wb.rd_wen && (wb.rd != '0);

    always_ff @(posedge clk) begin
        if (wb_write)
            regs[wb.rd] <= wb.value;
    end

    // Write-first read
    assign rs1_value = (rs1 == '0)                  ? '0       :
                       (wb_write && (wb.rd == rs1)) ? wb.value : regs[rs1];
    assign rs2_value = (rs2 == '0)                  ? '0       :
                       (wb_write && (wb.rd == rs2)) ? wb.value : regs[rs2];

endmodule

`default_nettype wire

//--- hdl/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  logic             clk,
    input  logic             rst,
    input  rv_pkg::if_id_t   if_id,
    input  logic             stall,
    input  logic             flush,
    input  rv_pkg::word_t    fwd_rs1_value,
    input  rv_pkg::word_t    fwd_rs2_value,
    input  rv_pkg::retire_t  wb,
    output rv_pkg::reg_idx_t rs1,
    output rv_pkg::reg_idx_t rs2,
    output rv_pkg::word_t    raw_rs1_value,
    output rv_pkg::word_t    raw_rs2_value,
    output rv_pkg::id_ex_t   id_ex
);
    import rv_pkg::*;

    word_t      inst;
    opcode_e    opcode;
    logic [2:0] funct3;
    logic       uses_rs1;
    logic       uses_rs2;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;
    id_ex_t     dec;

    assign inst   = if_id.inst;
    assign opcode = opcode_e'(inst[6:0]);
    assign funct3 = inst[14:12];

    // Unused source fields must not trigger a load-use stall
    assign uses_rs1 = if_id.valid && (opcode != OPC_LUI) && (opcode != OPC_JAL);
    assign uses_rs2 = if_id.valid &&
                      (opcode == OPC_OP || opcode == OPC_STORE || opcode == OPC_BRANCH);
    assign rs1 = uses_rs1 ? inst[19:15] : '0;
    assign rs2 = uses_rs2 ? inst[24:20] : '0;

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    reg_file i_reg_file (
        .clk       (clk),
        .rs1       (rs1),
        .rs2       (rs2),
        .wb        (wb),
        .rs1_value (raw_rs1_value),
        .rs2_value (raw_rs2_value)
    );

    always_comb begin
        dec           = '0;
        dec.valid     = if_id.valid;
        dec.pc        = if_id.pc;
        dec.rs1_value = fwd_rs1_value;
        dec.rs2_value = fwd_rs2_value;
        case (opcode)
            OPC_OP: begin
                dec.rd_wen = 1'b1;
                case (funct3)
                    3'b000:  dec.alu_op = inst[30] ? ALU_SUB : ALU_ADD;
                    3'b010:  dec.alu_op = ALU_SLT;
                    3'b100:  dec.alu_op = ALU_XOR;
                    3'b110:  dec.alu_op = ALU_OR;
                    3'b111:  dec.alu_op = ALU_AND;
                    default: dec.valid  = 1'b0;    // Shifts, SLTU
                endcase
            end
            OPC_OP_IMM: begin
                dec.rd_wen  = 1'b1;
                dec.use_imm = 1'b1;
                dec.imm     = imm_i;
                if (funct3 != 3'b000)
                    dec.valid = 1'b0;              // ADDI only
            end
            OPC_LUI: begin
                dec.rd_wen  = 1'b1;
                dec.use_imm = 1'b1;
                dec.imm     = imm_u;
                dec.alu_op  = ALU_PASS_B;
            end
            OPC_LOAD: begin
                dec.rd_wen  = 1'b1;
                dec.is_load = 1'b1;
                dec.use_imm = 1'b1;
                dec.imm     = imm_i;
            end
            OPC_STORE: begin
                dec.is_store = 1'b1;
                dec.use_imm  = 1'b1;
                dec.imm      = imm_s;
            end
            OPC_BRANCH: begin
                dec.is_branch = 1'b1;
                dec.branch_ne = funct3[0];
                dec.imm       = imm_b;
                if (funct3[2:1] != 2'b00)
                    dec.valid = 1'b0;              // BEQ and BNE only
            end
            OPC_JAL: begin
                dec.rd_wen  = 1'b1;
                dec.is_jump = 1'b1;
                dec.imm     = imm_j;
            end
            default: dec.valid = 1'b0;
        endcase
        if (dec.rd_wen)
            dec.rd = inst[11:7];
    end

    always_ff @(posedge clk) begin
        id_ex <= dec;
        if (rst || stall || flush)
            id_ex.valid <= 1'b0;   // Bubble
    end

endmodule

`default_nettype wire

//--- hdl/hazard_control.sv
`timescale 1ns/1ps
`default_nettype none

module hazard_control (
    input  rv_pkg::reg_idx_t  rs1,
    input  rv_pkg::reg_idx_t  rs2,
    input  rv_pkg::word_t     raw_rs1_value,
    input  rv_pkg::word_t     raw_rs2_value,
    input  rv_pkg::id_ex_t    ex,
    input  rv_pkg::word_t     ex_result,
    input  rv_pkg::ex_mem_t   mem,
    input  rv_pkg::word_t     dmem_rdata,
    input  rv_pkg::retire_t   wb,
    input  rv_pkg::redirect_t redirect,
    output rv_pkg::word_t     fwd_rs1_value,
    output rv_pkg::word_t     fwd_rs2_value,
    output logic              stall,
    output logic              flush
);
    import rv_pkg::*;

    word_t mem_value;
    logic  load_use;

    function automatic logic hits(reg_idx_t idx, logic valid, logic wen, reg_idx_t rd);
        return valid && wen && (rd != '0) && (rd == idx);
    endfunction

    // Youngest producer wins
    function automatic word_t forward(reg_idx_t idx, word_t raw, id_ex_t ex_s, word_t ex_v,
                                      ex_mem_t mem_s, word_t mem_v, retire_t wb_s);
        if (hits(idx, ex_s.valid, ex_s.rd_wen, ex_s.rd))
            return ex_v;
        if (hits(idx, mem_s.valid, mem_s.rd_wen, mem_s.rd))
            return mem_v;
        if (hits(idx, wb_s.valid, wb_s.rd_wen, wb_s.rd))
            return wb_s.value;
        return raw;
    endfunction

    assign mem_value = mem.is_load ? dmem_rdata : mem.result;

    assign fwd_rs1_value = forward(rs1, raw_rs1_value, ex, ex_result, mem, mem_value, wb);
    assign fwd_rs2_value = forward(rs2, raw_rs2_value, ex, ex_result, mem, mem_value, wb);

    // Load data is not ready until MEM
    assign load_use = ex.is_load && (hits(rs1, ex.valid, ex.rd_wen, ex.rd) ||
                                     hits(rs2, ex.valid, ex.rd_wen, ex.rd));

    assign flush = redirect.valid;
    assign stall = load_use && !redirect.valid;

endmodule

`default_nettype wire

//--- hdl/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  logic              clk,
    input  logic              rst,
    input  rv_pkg::id_ex_t    id_ex,
    output rv_pkg::word_t     ex_result,
    output rv_pkg::redirect_t redirect,
    output rv_pkg::ex_mem_t   ex_mem
);
    import rv_pkg::*;

    word_t   op_a;
    word_t   op_b;
    word_t   alu_out;
    logic    taken;
    ex_mem_t nxt;

    assign op_a = id_ex.rs1_value;
    assign op_b = id_ex.use_imm ? id_ex.imm : id_ex.rs2_value;

    always_comb begin
        case (id_ex.alu_op)
            ALU_ADD:    alu_out = op_a + op_b;
            ALU_SUB:    alu_out = op_a - op_b;
            ALU_AND:    alu_out = op_a & op_b;
            ALU_OR:     alu_out = op_a | op_b;
            ALU_XOR:    alu_out = op_a ^ op_b;
            ALU_SLT:    alu_out = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_PASS_B: alu_out = op_b;
            default:    alu_out = op_a + op_b;
        endcase
    end

    assign ex_result = id_ex.is_jump ? id_ex.pc + 32'd4 : alu_out;   // Link value for JAL

    // BEQ when branch_ne is low, BNE when high
    assign taken = id_ex.is_branch &&
                   ((id_ex.rs1_value == id_ex.rs2_value) != id_ex.branch_ne);

    assign redirect.valid  = id_ex.valid && (id_ex.is_jump || taken);
    assign redirect.target = id_ex.pc + id_ex.imm;

    always_comb begin
        nxt.valid      = id_ex.valid;
        nxt.pc         = id_ex.pc;
        nxt.rd         = id_ex.rd;
        nxt.rd_wen     = id_ex.rd_wen;
        nxt.is_load    = id_ex.is_load;
        nxt.is_store   = id_ex.is_store;
        nxt.result     = ex_result;
        nxt.store_data = id_ex.rs2_value;
    end

    always_ff @(posedge clk) begin
        ex_mem <= nxt;
        if (rst)
            ex_mem.valid <= 1'b0;
    end

endmodule

`default_nettype wire

//--- hdl/mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mem_stage (
    input  logic              clk,
    input  logic              rst,
    input  rv_pkg::ex_mem_t   ex_mem,
    input  rv_pkg::word_t     dmem_rdata,
    output rv_pkg::dmem_req_t dmem,
    output rv_pkg::retire_t   retire
);
    import rv_pkg::*;

    retire_t wb_next;

    assign dmem.ren   = ex_mem.valid && ex_mem.is_load;
    assign dmem.wen   = ex_mem.valid && ex_mem.is_store;
    assign dmem.addr  = ex_mem.result;
    assign dmem.wdata = ex_mem.store_data;

    always_comb begin
        wb_next.valid  = ex_mem.valid;
        wb_next.pc     = ex_mem.pc;
        wb_next.rd     = ex_mem.rd;
        wb_next.rd_wen = ex_mem.rd_wen;
        if (!ex_mem.rd_wen)
            wb_next.value = '0;              // Stores and branches carry no value
        else if (ex_mem.is_load)
            wb_next.value = dmem_rdata;
        else
            wb_next.value = ex_mem.result;
    end

    always_ff @(posedge clk) begin
        retire <= wb_next;
        if (rst)
            retire.valid <= 1'b0;
    end

endmodule

`default_nettype wire

//--- hdl/rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core #(
    parameter rv_pkg::word_t RESET_PC = 32'h0000_0000
) (
    input  logic              clk,
    input  logic              rst,
    input  rv_pkg::word_t     imem_data,
    input  rv_pkg::word_t     dmem_rdata,
    output rv_pkg::word_t     imem_addr,
    output rv_pkg::dmem_req_t dmem,
    output rv_pkg::retire_t   retire
);
    import rv_pkg::*;

    if_id_t    if_id;
    id_ex_t    id_ex;
    ex_mem_t   ex_mem;
    redirect_t redirect;
    word_t     ex_result;
    logic      stall;
    logic      flush;
    reg_idx_t  rs1;
    reg_idx_t  rs2;
    word_t     raw_rs1_value;
    word_t     raw_rs2_value;
    word_t     fwd_rs1_value;
    word_t     fwd_rs2_value;

    fetch_stage #(
        .RESET_PC (RESET_PC)
    ) i_fetch (
        .clk       (clk),
        .rst       (rst),
        .stall     (stall),
        .redirect  (redirect),
        .imem_data (imem_data),
        .imem_addr (imem_addr),
        .if_id     (if_id)
    );

    decode_stage i_decode (
        .clk           (clk),
        .rst           (rst),
        .if_id         (if_id),
        .stall         (stall),
        .flush         (flush),
        .fwd_rs1_value (fwd_rs1_value),
        .fwd_rs2_value (fwd_rs2_value),
        .wb            (retire),
        .rs1           (rs1),
        .rs2           (rs2),
        .raw_rs1_value (raw_rs1_value),
        .raw_rs2_value (raw_rs2_value),
        .id_ex         (id_ex)
    );

    hazard_control i_hazard (
        .rs1           (rs1),
        .rs2           (rs2),
        .raw_rs1_value (raw_rs1_value),
        .raw_rs2_value (raw_rs2_value),
        .ex            (id_ex),
        .ex_result     (ex_result),
        .mem           (ex_mem),
        .dmem_rdata    (dmem_rdata),
        .wb            (retire),
        .redirect      (redirect),
        .fwd_rs1_value (fwd_rs1_value),
        .fwd_rs2_value (fwd_rs2_value),
        .stall         (stall),
        .flush         (flush)
    );

    execute_stage i_execute (
        .clk       (clk),
        .rst       (rst),
        .id_ex     (id_ex),
        .ex_result (ex_result),
        .redirect  (redirect),
        .ex_mem    (ex_mem)
    );

    mem_stage i_mem (
        .clk        (clk),
        .rst        (rst),
        .ex_mem     (ex_mem),
        .dmem_rdata (dmem_rdata),
        .dmem       (dmem),
        .retire     (retire)
    );

endmodule

`default_nettype wire

//--- include/rv_iss.svh
`ifndef RV_ISS_SVH
`define RV_ISS_SVH
`default_nettype none

function automatic logic [31:0] enc_r(logic [6:0] f7, logic [2:0] f3, logic [4:0] rd,
                                      logic [4:0] rs1, logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, rv_pkg::OPC_OP};
endfunction

// ADDI when opc is OP_IMM, LW when opc is LOAD
function automatic logic [31:0] enc_i(logic [6:0] opc, logic [2:0] f3, logic [4:0] rd,
                                      logic [4:0] rs1, logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] enc_sw(logic [4:0] rs2, logic [4:0] rs1, logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rv_pkg::OPC_STORE};
endfunction

function automatic logic [31:0] enc_b(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                      logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rv_pkg::OPC_BRANCH};
endfunction

function automatic logic [31:0] enc_lui(logic [4:0] rd, logic [19:0] imm);
    return {imm, rd, rv_pkg::OPC_LUI};
endfunction

function automatic logic [31:0] enc_jal(logic [4:0] rd, logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, rv_pkg::OPC_JAL};
endfunction

// Executes one instruction and returns what the core must retire for it
function automatic rv_pkg::retire_t iss_step(input rv_pkg::word_t inst,
                                             ref rv_pkg::word_t pc,
                                             ref rv_pkg::word_t regs [32],
                                             ref rv_pkg::word_t dmem [rv_pkg::word_t]);
    rv_pkg::retire_t r;
    rv_pkg::word_t   a;
    rv_pkg::word_t   b;
    rv_pkg::word_t   addr;
    rv_pkg::word_t   next_pc;

    a       = regs[inst[19:15]];
    b       = regs[inst[24:20]];
    next_pc = pc + 32'd4;
    r       = '0;
    r.valid = 1'b1;
    r.pc    = pc;
    case (inst[6:0])
        rv_pkg::OPC_OP: begin
            r.rd_wen = 1'b1;
            case (inst[14:12])
                3'b000:  r.value = inst[30] ? a - b : a + b;
                3'b010:  r.value = {31'b0, $signed(a) < $signed(b)};
                3'b100:  r.value = a ^ b;
                3'b110:  r.value = a | b;
                default: r.value = a & b;
            endcase
        end
        rv_pkg::OPC_OP_IMM: begin
            r.rd_wen = 1'b1;
            r.value  = a + {{20{inst[31]}}, inst[31:20]};
        end
        rv_pkg::OPC_LUI: begin
            r.rd_wen = 1'b1;
            r.value  = {inst[31:12], 12'b0};
        end
        rv_pkg::OPC_LOAD: begin
            addr     = (a + {{20{inst[31]}}, inst[31:20]}) >> 2;
            r.rd_wen = 1'b1;
            r.value  = dmem.exists(addr) ? dmem[addr] : '0;
        end
        rv_pkg::OPC_STORE: begin
            addr       = (a + {{20{inst[31]}}, inst[31:25], inst[11:7]}) >> 2;
            dmem[addr] = b;
        end
        rv_pkg::OPC_BRANCH: begin
            if ((a == b) != inst[12])
                next_pc = pc + {{19{inst[31]}}, inst[31], inst[7], inst[30:25],
                                inst[11:8], 1'b0};
        end
        default: begin
            r.rd_wen = 1'b1;
            r.value  = pc + 32'd4;
            next_pc  = pc + {{11{inst[31]}}, inst[31], inst[19:12], inst[20],
                             inst[30:21], 1'b0};
        end
    endcase
    if (r.rd_wen) begin
        r.rd = inst[11:7];
        if (r.rd != '0)
            regs[r.rd] = r.value;
    end
    pc = next_pc;
    return r;
endfunction

`default_nettype wire
`endif

//--- tb/tb_rv_core.sv
`timescale 1ns/1ps
`include "rv_iss.svh"
`default_nettype none

module tb_rv_core;
    import rv_pkg::*;

    localparam word_t RESET_PC = 32'h0000_0100;
    localparam int    SEED     = 32'h48ef532f;

    logic      clk;
    logic      rst;
    word_t     imem_data;
    word_t     dmem_rdata;
    word_t     imem_addr;
    dmem_req_t dmem;
    retire_t   retire;

    word_t     imem [0:511];
    word_t     dmem_mem [0:255];

    // Reference state owned by the compare process
    word_t     iss_regs [32];
    word_t     iss_dmem [word_t];
    word_t     iss_pc;
    retire_t   exp_r;

    word_t     emit_pc;
    string     test_name;
    int        expected;
    int        started = 0;
    int        finished = 0;
    int        retired = 0;
    int        total_retired = 0;
    int        check_errors = 0;
    int        setup_errors = 0;
    int        budget = 16;        // Cycle limit that grows with each test
    int        cycles = 0;

    rv_core #(
        .RESET_PC (RESET_PC)
    ) i_dut (
        .clk        (clk),
        .rst        (rst),
        .imem_data  (imem_data),
        .dmem_rdata (dmem_rdata),
        .imem_addr  (imem_addr),
        .dmem       (dmem),
        .retire     (retire)
    );

    assign imem_data  = imem[imem_addr[10:2]];
    assign dmem_rdata = dmem.ren ? dmem_mem[dmem.addr[9:2]] : '0;

    // Harmless ADDI x0 carrying the word index
    function automatic word_t imem_fill(input int idx);
        return enc_i(rv_pkg::OPC_OP_IMM, 3'b000, 5'd0, 5'd0, 12'(idx));
    endfunction

    function automatic word_t data_fill(input word_t addr);
        return (addr * 32'h9e37_79b1) ^ 32'h3c6e_f372;
    endfunction

    // Runs the model on copies up to the closing JAL
    function automatic int expected_retires(input word_t end_pc);
        word_t regs_c [32];
        word_t mem_c [word_t];
        word_t pc;
        int    n;
        regs_c = iss_regs;
        mem_c  = iss_dmem;
        pc     = RESET_PC;
        n      = 1;
        while (pc != end_pc && n < 1000) begin
            void'(iss_step(imem[pc[10:2]], pc, regs_c, mem_c));
            n++;
        end
        return n;
    endfunction

    function automatic word_t random_inst();
        int          kind;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] off;
        kind = int'($urandom % 9);
        rd   = 5'(1 + $urandom % 7);
        rs1  = 5'($urandom % 8);
        rs2  = 5'($urandom % 8);
        off  = 12'(($urandom % 16) * 4);
        case (kind)
            0:       return enc_r(7'h00, 3'b000, rd, rs1, rs2);
            1:       return enc_r(7'h20, 3'b000, rd, rs1, rs2);
            2:       return enc_r(7'h00, 3'b111, rd, rs1, rs2);
            3:       return enc_r(7'h00, 3'b110, rd, rs1, rs2);
            4:       return enc_r(7'h00, 3'b100, rd, rs1, rs2);
            5:       return enc_r(7'h00, 3'b010, rd, rs1, rs2);
            6:       return enc_i(rv_pkg::OPC_OP_IMM, 3'b000, rd, rs1, 12'($urandom));
            7:       return enc_i(rv_pkg::OPC_LOAD, 3'b010, rd, 5'd8, off);   // x8 is the base
            default: return enc_sw(rs2, 5'd8, off);
        endcase
    endfunction

    task automatic emit(input word_t inst);
        imem[emit_pc[10:2]] = inst;
        emit_pc = emit_pc + 32'd4;
    endtask

    task automatic start_test(input string name);
        @(negedge clk);
        rst = 1'b1;
        test_name = name;
        for (int i = 0; i < 512; i++)
            imem[9'(i)] = imem_fill(i);
        emit_pc = RESET_PC;
    endtask

    task automatic run_test();
        int errors_before;
        int retired_before;
        errors_before  = check_errors + setup_errors;
        retired_before = total_retired;
        expected = expected_retires(emit_pc - 32'd4);
        budget   = budget + expected * 20 + 10;
        repeat (7) @(negedge clk);
        if (retire.valid !== 1'b0 || dmem.ren !== 1'b0 || dmem.wen !== 1'b0) begin
            $display("%s: core outputs not idle during reset", test_name);
            setup_errors++;
        end
        @(negedge clk);
        rst = 1'b0;
        started++;
        while (started != finished)
            @(negedge clk);
        for (int i = 0; i < 256; i++) begin
            if (dmem_mem[8'(i)] !== iss_dmem[word_t'(i)]) begin
                $display("ERR %s mem word %0d expected %h actual %h", test_name, i,
                         iss_dmem[word_t'(i)], dmem_mem[8'(i)]);
                setup_errors++;
            end
        end
        $display("%s: %0d retired, %0d errors", test_name, total_retired - retired_before,
                 check_errors + setup_errors - errors_before);
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Data memory model written in the MEM cycle
    initial begin
        for (int i = 0; i < 256; i++)
            dmem_mem[8'(i)] = data_fill(word_t'(i) << 2);
        forever begin
            @(negedge clk);
            if (dmem.wen)
                dmem_mem[dmem.addr[9:2]] = dmem.wdata;
        end
    end

    // Compare every retirement with the reference model
    initial begin
        for (int i = 0; i < 32; i++)
            iss_regs[5'(i)] = '0;
        for (int i = 0; i < 256; i++)
            iss_dmem[word_t'(i)] = data_fill(word_t'(i) << 2);
        iss_pc = RESET_PC;
        forever begin
            @(negedge clk);
            if (started != finished) begin
                if (retired == 0 && !retire.valid && (dmem.ren || dmem.wen)) begin
                    $display("%s: data memory access before the first retirement", test_name);
                    check_errors++;
                end
                if (retire.valid) begin
                    exp_r = iss_step(imem[iss_pc[10:2]], iss_pc, iss_regs, iss_dmem);
                    if (retired == 0 && retire.pc !== RESET_PC) begin
                        $display("ERR %s first pc expected %h actual %h", test_name,
                                 RESET_PC, retire.pc);
                        check_errors++;
                    end
                    if (retire !== exp_r) begin
                        $display("ERR %s retire expected %h actual %h", test_name,
                                 exp_r, retire);
                        check_errors++;
                    end
                    retired++;
                    total_retired++;
                    if (retired == expected) begin
                        retired = 0;
                        iss_pc  = RESET_PC;
                        finished++;
                    end
                end
            end
        end
    end

    initial begin
        while (cycles <= budget) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the run went past %0d cycles without finishing", budget);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        rst = 1'b1;
        void'($urandom(SEED));
        for (int i = 0; i < 512; i++)
            imem[9'(i)] = imem_fill(i);

        start_test("reset");
        emit(enc_i(rv_pkg::OPC_OP_IMM, 3'b000, 5'd1, 5'd0, 12'd5));
        emit(enc_i(rv_pkg::OPC_OP_IMM, 3'b000, 5'd2, 5'd1, 12'd7));
        emit(enc_jal(5'd0, 21'd0));
        run_test();

        start_test("alu_fwd");
        emit(enc_lui(5'd1, 20'h12345));
        emit(enc_i(rv_pkg::OPC_OP_IMM, 3'b000, 5'd1, 5'd1, 12'h678));
        emit(enc_i(rv_pkg::OPC_OP_IMM, 3'b000, 5'd2, 5'd0, 12'hffd));
        emit(enc_r(7'h00, 3'b000, 5'd3, 5'd1, 5'd2));     // EX forward
        emit(enc_r(7'h20, 3'b000, 5'd4, 5'd3, 5'd1));
        emit(enc_r(7'h00, 3'b111, 5'd5, 5'd4, 5'd1));
        emit(enc_r(7'h00, 3'b110, 5'd6, 5'd5, 5'd2));
        emit(enc_r(7'h00, 3'b100, 5'd7, 5'd6, 5'd3));
        emit(enc_r(7'h00, 3'b010, 5'd8, 5'd2, 5'd1));
        emit(enc_r(7'h00, 3'b010, 5'd9, 5'd1, 5'd2));
        emit(enc_i(rv_pkg::OPC_OP_IMM, 3'b000, 5'd0, 5'd1, 12'd1));   // Write to x0
        emit(enc_r(7'h00, 3'b000, 5'd10, 5'd0, 5'd1));
        emit(enc_r(7'h00, 3'b000, 5'd11, 5'd0, 5'd0));
        emit(enc_r(7'h00, 3'b000, 5'd12, 5'd1, 5'd8));
        emit(enc_jal(5'd0, 21'd0));
        run_test();

        start_test("mem_load_use");
        emit(enc_i(rv_pkg::OPC_OP_IMM, 3'b000, 5'd8, 5'd0, 12'h080));
        emit(enc_lui(5'd1, 20'hcafe0));
        emit(enc_i(rv_pkg::OPC_OP_IMM, 3'b000, 5'd1, 5'd1, 12'h3a5));
        emit(enc_sw(5'd1, 5'd8, 12'd0));
        emit(enc_i(rv_pkg::OPC_LOAD, 3'b010, 5'd2, 5'd8, 12'd0));
        emit(enc_r(7'h00, 3'b000, 5'd3, 5'd2, 5'd2));     // Load-use
        emit(enc_sw(5'd3, 5'd8, 12'd4));
        emit(enc_i(rv_pkg::OPC_LOAD, 3'b010, 5'd4, 5'd8, 12'd4));
        emit(enc_sw(5'd4, 5'd8, 12'd8));                  // Load-use on store data
        emit(enc_i(rv_pkg::OPC_LOAD, 3'b010, 5'd5, 5'd8, 12'd12));
        emit(enc_i(rv_pkg::OPC_OP_IMM, 3'b000, 5'd6, 5'd5, 12'd1));
        emit(enc_i(rv_pkg::OPC_LOAD, 3'b010, 5'd7, 5'd8, 12'd8));
        emit(enc_jal(5'd0, 21'd0));
        run_test();

        start_test("control");
        emit(enc_i(rv_pkg::OPC_OP_IMM, 3'b000, 5'd1, 5'd0, 12'd1));
        emit(enc_i(rv_pkg::OPC_OP_IMM, 3'b000, 5'd2, 5'd0, 12'd1));
        emit(enc_b(3'b000, 5'd1, 5'd2, 13'd12));          // Taken BEQ
        emit(enc_i(rv_pkg::OPC_OP_IMM, 3'b000, 5'd3, 5'd0, 12'd99));
        emit(enc_i(rv_pkg::OPC_OP_IMM, 3'b000, 5'd3, 5'd0, 12'd98));
        emit(enc_b(3'b001, 5'd1, 5'd2, 13'd8));           // BNE not taken
        emit(enc_i(rv_pkg::OPC_OP_IMM, 3'b000, 5'd4, 5'd0, 12'd4));
        emit(enc_b(3'b000, 5'd1, 5'd0, 13'd8));
        emit(enc_jal(5'd5, 21'd12));
        emit(enc_i(rv_pkg::OPC_OP_IMM, 3'b000, 5'd6, 5'd0, 12'd66));
        emit(enc_i(rv_pkg::OPC_OP_IMM, 3'b000, 5'd6, 5'd0, 12'd67));
        emit(enc_b(3'b001, 5'd5, 5'd0, 13'd8));           // Uses the link value
        emit(enc_i(rv_pkg::OPC_OP_IMM, 3'b000, 5'd7, 5'd0, 12'd77));
        emit(enc_r(7'h00, 3'b000, 5'd7, 5'd5, 5'd4));
        emit(enc_jal(5'd0, 21'd0));
        run_test();

        start_test("random");
        emit(enc_i(rv_pkg::OPC_OP_IMM, 3'b000, 5'd8, 5'd0, 12'h080));
        for (int r = 1; r < 8; r++) begin
            emit(enc_lui(5'(r), 20'($urandom)));
            emit(enc_i(rv_pkg::OPC_OP_IMM, 3'b000, 5'(r), 5'(r), 12'($urandom)));
        end
        repeat (200)
            emit(random_inst());
        emit(enc_jal(5'd0, 21'd0));
        run_test();

        $display("summary: %0d retired, %0d errors", total_retired,
                 check_errors + setup_errors);
        if (check_errors + setup_errors == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
+incdir+include
hdl/rv_pkg.sv
hdl/fetch_stage.sv
hdl/reg_file.sv
hdl/decode_stage.sv
hdl/hazard_control.sv
hdl/execute_stage.sv
hdl/mem_stage.sv
hdl/rv_core.sv
tb/tb_rv_core.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     = --timing --timescale 1ns/1ps
TOP       = tb_rv_core
FILELIST  = files.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^TEST OK$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
